// ==== Bender.yml ====
package:
  name: global_prediction

sources:
  - files:
      - hdl/bp_addr_pkg.sv
      - hdl/bp_pred_pkg.sv
      - hdl/bp_resolve_if.sv
      - hdl/global_history_register.sv
      - hdl/pattern_history_table.sv
      - hdl/branch_target_buffer.sv
      - hdl/branch_correction_buffer.sv
      - hdl/fetch_pc_unit.sv
      - hdl/global_prediction_top.sv
  - target: test
    files:
      - verif/global_prediction_tb.sv

// ==== global_prediction.f ====
hdl/bp_addr_pkg.sv
hdl/bp_pred_pkg.sv
hdl/bp_resolve_if.sv
hdl/global_history_register.sv
hdl/pattern_history_table.sv
hdl/branch_target_buffer.sv
hdl/branch_correction_buffer.sv
hdl/fetch_pc_unit.sv
hdl/global_prediction_top.sv
verif/global_prediction_tb.sv

// ==== hdl/bp_addr_pkg.sv ====
package bp_addr_pkg;

    // Width of a fetch address
    localparam int unsigned ADDR_BITS = 32;

    // Byte address of an instruction, always word aligned
    typedef logic [ADDR_BITS-1:0] addr_t;

    // Step between sequential fetches
    localparam int unsigned INSTR_BYTES = 4;

    // Low address bits below the table index
    // Always zero for aligned instructions
    localparam int unsigned OFFSET_BITS = 2;

    // Tag width left above a table index of idx_bits
    function automatic int unsigned tag_bits(int unsigned idx_bits);
        return ADDR_BITS - idx_bits - OFFSET_BITS;
    endfunction

    // Address of the first word that maps to a table index
    function automatic addr_t index_base(int unsigned idx);
        return addr_t'(idx) << OFFSET_BITS;
    endfunction

endpackage

// ==== hdl/bp_pred_pkg.sv ====
package bp_pred_pkg;

    // Two-bit counter, upper bit is the direction prediction
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_e;

    // State of every counter after reset
    localparam ctr_e CTR_RESET = weak_nt;

    // Predicted direction of a counter
    function automatic logic ctr_pred(ctr_e state);
        return state[1];
    endfunction

    // One saturating step toward the resolved outcome
    function automatic ctr_e ctr_next(ctr_e state, logic taken);
        ctr_e next;
        unique case (state)
            strong_nt: next = taken ? weak_nt  : strong_nt;
            weak_nt:   next = taken ? weak_t   : strong_nt;
            weak_t:    next = taken ? strong_t : weak_nt;
            default:   next = taken ? strong_t : weak_t;
        endcase
        return next;
    endfunction

endpackage

// ==== hdl/bp_resolve_if.sv ====
`timescale 1ns/1ps

interface bp_resolve_if;

    // Resolution is present this cycle
    logic                 valid;
    // Conditional branch
    logic                 branch;
    // Unconditional jump, counts as taken
    logic                 jump;
    // Resolved direction of a branch
    logic                 taken;
    // Address of the resolved instruction
    bp_addr_pkg::addr_t   pc;
    // Resolved destination when taken
    bp_addr_pkg::addr_t   target;

    // Execute stage side
    modport producer (
        output valid, branch, jump, taken, pc, target
    );

    // Predictor tables and correction buffer
    modport consumer (
        input valid, branch, jump, taken, pc, target
    );

endinterface

// ==== hdl/branch_correction_buffer.sv ====
`timescale 1ns/1ps

module branch_correction_buffer #(
    parameter int unsigned IDX_BITS = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    bp_resolve_if.consumer     res,
    input  bp_addr_pkg::addr_t fetch_pc,
    input  logic               fetch_fire,
    input  bp_addr_pkg::addr_t pred_next,
    output logic               mispredict,
    output bp_addr_pkg::addr_t redirect_pc
);

    localparam int unsigned DEPTH = 2 ** IDX_BITS;

    // Predicted next address of the latest fetch per index
    bp_addr_pkg::addr_t  rec_q [DEPTH];

    logic [IDX_BITS-1:0] fetch_idx;
    logic [IDX_BITS-1:0] res_idx;
    logic                res_taken;
    bp_addr_pkg::addr_t  actual_next;

    assign fetch_idx = fetch_pc[bp_addr_pkg::OFFSET_BITS +: IDX_BITS];
    assign res_idx   = res.pc[bp_addr_pkg::OFFSET_BITS +: IDX_BITS];

    // Taken branch or jump leaves the sequential path
    assign res_taken   = (res.branch && res.taken) || res.jump;
    assign actual_next = res_taken ? res.target : res.pc + bp_addr_pkg::INSTR_BYTES;

    // Compare against the record before any write at this edge
    assign mispredict  = res.valid && (actual_next != rec_q[res_idx]);
    assign redirect_pc = actual_next;

    // Reset records match the PC+4 that an empty BTB predicts
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                rec_q[i] <= bp_addr_pkg::index_base(i) + bp_addr_pkg::INSTR_BYTES;
            end
        end else if (fetch_fire) begin
            rec_q[fetch_idx] <= pred_next;
        end
    end

endmodule

// ==== hdl/branch_target_buffer.sv ====
`timescale 1ns/1ps

module branch_target_buffer #(
    parameter int unsigned IDX_BITS = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    bp_resolve_if.consumer     res,
    input  bp_addr_pkg::addr_t fetch_pc,
    output logic               hit,
    output bp_addr_pkg::addr_t target
);

    localparam int unsigned DEPTH    = 2 ** IDX_BITS;
    localparam int unsigned TAG_BITS = bp_addr_pkg::tag_bits(IDX_BITS);
    localparam int unsigned TAG_LSB  = bp_addr_pkg::OFFSET_BITS + IDX_BITS;

    logic [DEPTH-1:0]         valid_q;
    logic [TAG_BITS-1:0]      tag_q    [DEPTH];
    bp_addr_pkg::addr_t       target_q [DEPTH];

    logic [IDX_BITS-1:0]      fetch_idx;
    logic [TAG_BITS-1:0]      fetch_tag;
    logic [IDX_BITS-1:0]      res_idx;
    logic [TAG_BITS-1:0]      res_tag;
    logic                     fill_en;

    // Fetch side lookup
    assign fetch_idx = fetch_pc[bp_addr_pkg::OFFSET_BITS +: IDX_BITS];
    assign fetch_tag = fetch_pc[TAG_LSB +: TAG_BITS];

    // Resolution side write address
    assign res_idx = res.pc[bp_addr_pkg::OFFSET_BITS +: IDX_BITS];
    assign res_tag = res.pc[TAG_LSB +: TAG_BITS];

    assign hit    = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);
    assign target = target_q[fetch_idx];

    // Any taken control transfer fills or replaces its entry
    assign fill_en = res.valid && ((res.branch && res.taken) || res.jump);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[res_idx] <= 1'b1;
        end
    end

    // Tag and target of each entry
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[res_idx]    <= res_tag;
            target_q[res_idx] <= res.target;
        end
    end

endmodule

// ==== hdl/fetch_pc_unit.sv ====
`timescale 1ns/1ps

module fetch_pc_unit #(
    parameter bp_addr_pkg::addr_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               fetch_ready,
    output logic               fetch_valid,
    output bp_addr_pkg::addr_t fetch_pc,
    input  logic               pred_taken,
    input  logic               hit,
    input  bp_addr_pkg::addr_t target,
    input  logic               mispredict,
    input  bp_addr_pkg::addr_t redirect_pc,
    output bp_addr_pkg::addr_t pred_next,
    output logic               fetch_fire
);

    bp_addr_pkg::addr_t pc_q;
    logic               valid_q;

    assign fetch_pc    = pc_q;
    assign fetch_valid = valid_q;
    assign fetch_fire  = valid_q && fetch_ready;

    // Follow the BTB only when the PHT also says taken
    assign pred_next = (pred_taken && hit) ? target : pc_q + bp_addr_pkg::INSTR_BYTES;

    // Valid rises at the first edge after reset release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
        end
    end

    // Redirect first, then an accepted prediction
    // Stall holds the PC
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= RESET_PC;
        end else if (mispredict) begin
            pc_q <= redirect_pc;
        end else if (fetch_fire) begin
            pc_q <= pred_next;
        end
    end

endmodule

// ==== hdl/global_history_register.sv ====
`timescale 1ns/1ps

module global_history_register #(
    parameter int unsigned HIST_BITS = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    bp_resolve_if.consumer       res,
    output logic [HIST_BITS-1:0] history
);

    logic shift_en;

    // Only conditional branches enter the history
    // Jumps carry no direction information
    assign shift_en = res.valid && res.branch;

    // Newest outcome at bit 0
    // Oldest one falls off the top
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            history <= '0;
        end else if (shift_en) begin
            history <= HIST_BITS'({history, res.taken});
        end
    end

endmodule

// ==== hdl/global_prediction_top.sv ====
`timescale 1ns/1ps

module global_prediction_top #(
    parameter int unsigned        HIST_BITS = 4,
    parameter int unsigned        IDX_BITS  = 4,
    parameter bp_addr_pkg::addr_t RESET_PC  = '0
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               fetch_ready,
    output logic               fetch_valid,
    output bp_addr_pkg::addr_t fetch_pc,
    output logic               fetch_pred_taken,
    input  logic               res_valid,
    input  logic               res_branch,
    input  logic               res_jump,
    input  logic               res_taken,
    input  bp_addr_pkg::addr_t res_pc,
    input  bp_addr_pkg::addr_t res_target,
    output logic               mispredict
);

    logic [HIST_BITS-1:0] history;
    logic                 pht_taken;
    logic                 btb_hit;
    bp_addr_pkg::addr_t   btb_target;
    bp_addr_pkg::addr_t   pred_next;
    bp_addr_pkg::addr_t   redirect_pc;
    logic                 fetch_fire;

    // Execute stage resolution, fanned out to all trainers
    bp_resolve_if res_if ();

    assign res_if.valid  = res_valid;
    assign res_if.branch = res_branch;
    assign res_if.jump   = res_jump;
    assign res_if.taken  = res_taken;
    assign res_if.pc     = res_pc;
    assign res_if.target = res_target;

    // Same condition the fetch unit uses to pick the BTB target
    assign fetch_pred_taken = pht_taken && btb_hit;

    global_history_register #(.HIST_BITS(HIST_BITS)) u_ghr (
        .clk     (clk),
        .arst_n  (arst_n),
        .res     (res_if),
        .history (history)
    );

    pattern_history_table #(.HIST_BITS(HIST_BITS)) u_pht (
        .clk        (clk),
        .arst_n     (arst_n),
        .res        (res_if),
        .history    (history),
        .pred_taken (pht_taken)
    );

    branch_target_buffer #(.IDX_BITS(IDX_BITS)) u_btb (
        .clk      (clk),
        .arst_n   (arst_n),
        .res      (res_if),
        .fetch_pc (fetch_pc),
        .hit      (btb_hit),
        .target   (btb_target)
    );

    branch_correction_buffer #(.IDX_BITS(IDX_BITS)) u_bcb (
        .clk         (clk),
        .arst_n      (arst_n),
        .res         (res_if),
        .fetch_pc    (fetch_pc),
        .fetch_fire  (fetch_fire),
        .pred_next   (pred_next),
        .mispredict  (mispredict),
        .redirect_pc (redirect_pc)
    );

    fetch_pc_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_ready (fetch_ready),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .pred_taken  (pht_taken),
        .hit         (btb_hit),
        .target      (btb_target),
        .mispredict  (mispredict),
        .redirect_pc (redirect_pc),
        .pred_next   (pred_next),
        .fetch_fire  (fetch_fire)
    );

endmodule

// ==== hdl/pattern_history_table.sv ====
`timescale 1ns/1ps

module pattern_history_table #(
    parameter int unsigned HIST_BITS = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    bp_resolve_if.consumer       res,
    input  logic [HIST_BITS-1:0] history,
    output logic                 pred_taken
);

    // One counter per history pattern
    localparam int unsigned DEPTH = 2 ** HIST_BITS;

    bp_pred_pkg::ctr_e ctr_q [DEPTH];
    bp_pred_pkg::ctr_e ctr_sel;
    logic              update_en;

    // Counter picked by the current history
    assign ctr_sel = ctr_q[history];

    // Prediction from the registered table
    assign pred_taken = bp_pred_pkg::ctr_pred(ctr_sel);

    // Train on every resolved conditional branch
    assign update_en = res.valid && res.branch;

    // History is not updated speculatively
    // so the entry trained is the one predicting now
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                ctr_q[i] <= bp_pred_pkg::CTR_RESET;
            end
        end else if (update_en) begin
            ctr_q[history] <= bp_pred_pkg::ctr_next(ctr_sel, res.taken);
        end
    end

endmodule

// ==== verif/global_prediction_tb.sv ====
`timescale 1ns/1ps

module global_prediction_tb;

    localparam int unsigned        HIST_BITS = 4;
    localparam int unsigned        IDX_BITS  = 4;
    localparam bp_addr_pkg::addr_t RESET_PC  = 32'h0000_0000;
    localparam int unsigned        DEPTH_H   = 2 ** HIST_BITS;
    localparam int unsigned        DEPTH_I   = 2 ** IDX_BITS;
    localparam logic [31:0]        SEED      = 32'h5dc9a30c;

    logic               clk;
    logic               arst_n;
    logic               fetch_ready;
    logic               fetch_valid;
    bp_addr_pkg::addr_t fetch_pc;
    logic               fetch_pred_taken;
    logic               res_valid;
    logic               res_branch;
    logic               res_jump;
    logic               res_taken;
    bp_addr_pkg::addr_t res_pc;
    bp_addr_pkg::addr_t res_target;
    logic               mispredict;

    // Reference model state
    bp_addr_pkg::addr_t   m_pc;
    logic                 m_valid;
    logic [HIST_BITS-1:0] m_hist;
    logic [1:0]           m_ctr     [DEPTH_H];
    logic                 m_btb_v   [DEPTH_I];
    bp_addr_pkg::addr_t   m_btb_pc  [DEPTH_I];
    bp_addr_pkg::addr_t   m_btb_tgt [DEPTH_I];
    bp_addr_pkg::addr_t   m_rec     [DEPTH_I];

    // Fetches awaiting resolution in fetch order
    bp_addr_pkg::addr_t q_pc   [$];
    int                 q_seq  [$];
    int                 q_time [$];
    int                 last_seq [DEPTH_I];
    int                 seq;
    int                 cycle;
    logic [31:0]        rng;
    string              test_name;

    global_prediction_top #(
        .HIST_BITS (HIST_BITS),
        .IDX_BITS  (IDX_BITS),
        .RESET_PC  (RESET_PC)
    ) u_dut (
        .clk              (clk),
        .arst_n           (arst_n),
        .fetch_ready      (fetch_ready),
        .fetch_valid      (fetch_valid),
        .fetch_pc         (fetch_pc),
        .fetch_pred_taken (fetch_pred_taken),
        .res_valid        (res_valid),
        .res_branch       (res_branch),
        .res_jump         (res_jump),
        .res_taken        (res_taken),
        .res_pc           (res_pc),
        .res_target       (res_target),
        .mispredict       (mispredict)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = lcg_step(rng);
        return rng;
    endfunction

    function automatic int unsigned index_of(bp_addr_pkg::addr_t pc);
        return (pc >> 2) % DEPTH_I;
    endfunction

    // Saturating two-bit count where 3 is strongly taken
    function automatic logic [1:0] count_step(logic [1:0] c, logic taken);
        if (taken) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    // Expected direction needs a taken counter and a matching BTB tag
    function automatic logic ref_pred_taken(bp_addr_pkg::addr_t pc);
        int unsigned i;
        i = index_of(pc);
        return m_ctr[m_hist][1] && m_btb_v[i]
            && ((m_btb_pc[i] >> (IDX_BITS + 2)) == (pc >> (IDX_BITS + 2)));
    endfunction

    function automatic bp_addr_pkg::addr_t ref_pred_next(bp_addr_pkg::addr_t pc);
        return ref_pred_taken(pc) ? m_btb_tgt[index_of(pc)] : pc + 32'd4;
    endfunction

    function automatic bp_addr_pkg::addr_t actual_next(logic branch, logic jump, logic taken,
                                                       bp_addr_pkg::addr_t pc,
                                                       bp_addr_pkg::addr_t target);
        if ((branch && taken) || jump) begin
            return target;
        end
        return pc + 32'd4;
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_addr(string what, bp_addr_pkg::addr_t exp, bp_addr_pkg::addr_t act);
        if (exp !== act) begin
            $display("error %s %s expected %h actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (exp !== act) begin
            $display("error %s %s expected %b actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    // One cycle of inputs applied at the rising edge
    task automatic drive(logic ready, logic valid, logic branch, logic jump, logic taken,
                         bp_addr_pkg::addr_t pc, bp_addr_pkg::addr_t target);
        @(posedge clk);
        fetch_ready <= ready;
        res_valid   <= valid;
        res_branch  <= branch;
        res_jump    <= jump;
        res_taken   <= taken;
        res_pc      <= pc;
        res_target  <= target;
    endtask

    task automatic wait_for_pc(bp_addr_pkg::addr_t pc, int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (fetch_pc !== pc) begin
            if (n == limit) begin
                $display("timed out in %s waiting for fetch_pc %h", test_name, pc);
                abort_run();
            end
            n++;
            @(negedge clk);
        end
    endtask

    // Check outputs mid-cycle and step the model across the next edge
    always @(negedge clk) begin : compare
        logic               exp_mis;
        logic               fire;
        bp_addr_pkg::addr_t act;
        bp_addr_pkg::addr_t pnext;
        int unsigned        ri;
        int unsigned        fi;
        ri      = index_of(res_pc);
        fi      = index_of(m_pc);
        act     = actual_next(res_branch, res_jump, res_taken, res_pc, res_target);
        exp_mis = res_valid && (act != m_rec[ri]);
        pnext   = ref_pred_next(m_pc);
        fire    = m_valid && fetch_ready;
        check_addr("fetch_pc", m_pc, fetch_pc);
        check_bit("fetch_valid", m_valid, fetch_valid);
        check_bit("fetch_pred_taken", ref_pred_taken(m_pc), fetch_pred_taken);
        check_bit("mispredict", exp_mis, mispredict);
        if (arst_n) begin
            if (fire) begin
                m_rec[fi] = pnext;
                seq++;
                last_seq[fi] = seq;
                q_pc.push_back(m_pc);
                q_seq.push_back(seq);
                q_time.push_back(cycle);
            end
            // Old history picks the counter and then the outcome shifts in
            if (res_valid && res_branch) begin
                m_ctr[m_hist] = count_step(m_ctr[m_hist], res_taken);
                m_hist = {m_hist[HIST_BITS-2:0], res_taken};
            end
            if (res_valid && ((res_branch && res_taken) || res_jump)) begin
                m_btb_v[ri]   = 1'b1;
                m_btb_pc[ri]  = res_pc;
                m_btb_tgt[ri] = res_target;
            end
            m_valid = 1'b1;
            // Younger fetches are wrong path after a redirect
            if (exp_mis) begin
                m_pc = act;
                q_pc.delete();
                q_seq.delete();
                q_time.delete();
            end else if (fire) begin
                m_pc = pnext;
            end
        end
        cycle++;
    end

    initial begin : stimulus
        bp_addr_pkg::addr_t held;
        bp_addr_pkg::addr_t rpc;
        bp_addr_pkg::addr_t tgt;
        logic               held_t;
        logic               found;
        logic [31:0]        w;
        logic [31:0]        r;
        int                 s;
        int                 n;
        rng         = SEED;
        cycle       = 0;
        seq         = 0;
        test_name   = "reset";
        arst_n      = 1'b0;
        fetch_ready = 1'b0;
        res_valid   = 1'b0;
        res_branch  = 1'b0;
        res_jump    = 1'b0;
        res_taken   = 1'b0;
        res_pc      = '0;
        res_target  = '0;
        m_pc        = RESET_PC;
        m_valid     = 1'b0;
        m_hist      = '0;
        for (int i = 0; i < DEPTH_H; i++) begin
            m_ctr[i] = 2'd1;
        end
        // Empty BTB predicts PC+4 for every index
        for (int i = 0; i < DEPTH_I; i++) begin
            m_btb_v[i]  = 1'b0;
            m_rec[i]    = (i << 2) + 4;
            last_seq[i] = -1;
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        n = 0;
        while (fetch_valid !== 1'b1) begin
            if (n == 4) begin
                $display("timed out waiting for fetch_valid after reset");
                abort_run();
            end
            n++;
            @(negedge clk);
        end

        test_name = "sequential";
        repeat (8) drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);

        test_name = "stall";
        drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        @(negedge clk);
        held   = fetch_pc;
        held_t = fetch_pred_taken;
        repeat (5) drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        @(negedge clk);
        check_addr("held_pc", held, fetch_pc);
        check_bit("held_pred", held_t, fetch_pred_taken);

        // The first one misses the BTB and later ones saturate the counters
        test_name = "train";
        repeat (6) drive(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 32'h10, 32'h80);
        test_name = "jump_redirect";
        drive(1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 32'h40, 32'h10);
        drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        wait_for_pc(32'h10, 4);
        check_bit("trained_pred", 1'b1, fetch_pred_taken);
        test_name = "wrong_direction";
        drive(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 32'h10, 32'h80);
        drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        wait_for_pc(32'h14, 4);

        test_name = "random";
        q_pc.delete();
        q_seq.delete();
        q_time.delete();
        for (int k = 0; k < 3000; k++) begin
            found = 1'b0;
            // Skip fetches whose record a newer fetch replaced
            while (!found && q_pc.size() > 0 && cycle - q_time[0] >= 2) begin
                rpc   = q_pc.pop_front();
                s     = q_seq.pop_front();
                q_time.delete(0);
                found = (s == last_seq[index_of(rpc)]);
            end
            r = next_rand();
            if (found) begin
                // Kind and target fixed per address
                w   = lcg_step(lcg_step(SEED ^ rpc));
                tgt = (bp_addr_pkg::addr_t'(w[12:10]) << 6)
                    + (bp_addr_pkg::addr_t'(w[9]) << 2);
                drive(r[31:30] != 2'b00, 1'b1, w[31:29] == 3'd5 || w[31:29] == 3'd6,
                      w[31:29] == 3'd7, r[20], rpc, tgt);
            end else begin
                drive(r[31:30] != 2'b00, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
            end
        end
        drive(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule
